/* compile.f */
logic/ahb_pkg.sv
logic/ahb_arbiter.sv
logic/ahb_decoder.sv
logic/ahb_mem_slave.sv
logic/ahb_sopc_top.sv
verif/tb_clock_gen.sv
verif/tb_ahb_sopc.sv

/* Makefile */
# Verilator build of the AHB fabric testbench, run from the project root
SIM      := verilator
FLAGS    := --binary --timing
TOP      := tb_ahb_sopc
FILELIST := compile.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
PASS_MSG := Done: no errors

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only if the pass message shows up on a line of its own
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* rom_init.hex */
// One 32-bit ROM word per line in hex, word address 0 first
20000137
00000513
00100593
00b50633
00c02023
00002683
00168693
00d02223
fe0698e3
deadbeef
0f0f0f0f
a5a55a5a
12345678
80000001
7ffffffe
0000006f

/* verif/tb_ahb_sopc.sv */
// Directed tests; run from the project root to find rom_init.hex; RAM model spans offsets 0..255
`timescale 1ns/1ns

module tb_ahb_sopc;
    import ahb_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int LIMIT      = 20;  // Cycles before a wait gives up
    localparam int ROM_LINES  = 16;  // Words held in rom_init.hex

    logic        clk;
    logic        rst;
    logic        m0_busreq;
    logic        m1_busreq;
    ahb_req_t    m0_req;
    ahb_req_t    m1_req;
    logic        m0_grant;
    logic        m1_grant;
    ahb_rsp_t    m_rsp;
    logic [31:0] rom_file [ROM_LINES];
    logic [7:0]  ram_model [256];    // Byte lanes of the RAM window
    int          value_errors;
    int          timeouts;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) tb_clock_gen_inst (.clk(clk));

    ahb_sopc_top #(
        .ROM_WORDS (256),
        .RAM_WORDS (1024)
    ) ahb_sopc_top_inst (
        .clk       (clk),
        .rst       (rst),
        .m0_busreq (m0_busreq),
        .m1_busreq (m1_busreq),
        .m0_req    (m0_req),
        .m1_req    (m1_req),
        .m0_grant  (m0_grant),
        .m1_grant  (m1_grant),
        .m_rsp     (m_rsp)
    );

    ////////////////////
    // Helpers
    ////////////////////
    task automatic flag_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        value_errors++;
        $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    endtask

    task automatic drive_req(input int mst, input ahb_req_t req);
        if (mst == 0) begin
            m0_req = req;
        end else begin
            m1_req = req;
        end
    endtask

    task automatic wait_grant(input int mst);
        int n;
        n = 0;
        while (((mst == 0) ? m0_grant : m1_grant) !== 1'b1 && n < LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (((mst == 0) ? m0_grant : m1_grant) !== 1'b1) begin
            timeouts++;
            $display("Timeout: master %0d never received a grant", mst);
        end
    endtask

    // Returns at the falling edge before the edge that closes its data phase
    task automatic do_transfer(input int mst, input logic [31:0] addr, input hsize_t size,
                               input logic write, input logic [31:0] wdata,
                               output logic [31:0] rdata, output hresp_t first_resp,
                               output hresp_t last_resp, output int waits);
        ahb_req_t req;
        int       n;
        req        = (mst == 0) ? m0_req : m1_req; // Earlier write data stays on the bus
        req.haddr  = addr;
        req.htrans = NONSEQ;
        req.hsize  = size;
        req.hwrite = write;
        drive_req(mst, req);
        n = 0;
        while (m_rsp.hready !== 1'b1 && n < LIMIT) begin // Stalled address phase
            n++;
            @(negedge clk);
        end
        if (m_rsp.hready !== 1'b1) begin
            timeouts++;
            $display("Timeout: address phase to %h was never accepted", addr);
        end
        @(negedge clk);
        req.htrans = IDLE;
        req.hwdata = wdata;                            // Data phase
        drive_req(mst, req);
        first_resp = m_rsp.hresp;
        waits = 0;
        while (m_rsp.hready !== 1'b1 && waits < LIMIT) begin
            waits++;
            @(negedge clk);
        end
        if (m_rsp.hready !== 1'b1) begin
            timeouts++;
            $display("Timeout: hready stayed low in the data phase to %h", addr);
        end
        rdata     = m_rsp.hrdata;
        last_resp = m_rsp.hresp;
    endtask

    task automatic check_okay(input string what, input hresp_t resp, input int waits);
        if (waits != 0) begin
            flag_mismatch($sformatf("%s wait cycles", what), 32'(waits), 32'd0);
        end
        if (resp !== OKAY) begin
            flag_mismatch($sformatf("%s response", what), 32'(resp), 32'(OKAY));
        end
    endtask

    // Two-cycle ERROR with ready low then high
    task automatic check_error(input string what, input hresp_t first, input hresp_t last,
                               input int waits);
        if (waits != 1) begin
            flag_mismatch($sformatf("%s wait cycles", what), 32'(waits), 32'd1);
        end
        if (first !== ERROR || last !== ERROR) begin
            flag_mismatch($sformatf("%s responses", what), 32'({first, last}), 32'b11);
        end
    endtask

    ////////////////////
    // RAM model
    ////////////////////
    task automatic model_write(input logic [7:0] off, input hsize_t size,
                               input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            if (size == WORD || (size == HALF && b[1] == off[1]) ||
                (size == BYTE && b[1:0] == off[1:0])) begin
                ram_model[{off[7:2], b[1:0]}] = data[8*b +: 8]; // Lane b of the bus
            end
        end
    endtask

    function automatic logic [31:0] model_word(input logic [7:0] off);
        return {ram_model[{off[7:2], 2'd3}], ram_model[{off[7:2], 2'd2}],
                ram_model[{off[7:2], 2'd1}], ram_model[{off[7:2], 2'd0}]};
    endfunction

    ////////////////////
    // Tests
    ////////////////////
    task automatic check_reset_state();
        if (m0_grant !== 1'b1 || m1_grant !== 1'b0) begin
            flag_mismatch("grants after reset", 32'({m1_grant, m0_grant}), 32'b01);
        end
        if (m_rsp.hready !== 1'b1 || m_rsp.hresp !== OKAY) begin
            flag_mismatch("hready/hresp after reset", 32'({m_rsp.hready, m_rsp.hresp}), 32'b10);
        end
    endtask

    task automatic read_rom();
        logic [31:0] rdata;
        hresp_t      first;
        hresp_t      last;
        int          waits;
        for (int i = 0; i < ROM_LINES; i++) begin
            do_transfer(0, ROM_BASE + 32'(4 * i), WORD, 1'b0, 32'h0, rdata, first, last, waits);
            check_okay("ROM read", last, waits);
            if (rdata !== rom_file[i]) begin
                flag_mismatch($sformatf("ROM word %0d", i), rdata, rom_file[i]);
            end
        end
    endtask

    task automatic exercise_ram_sizes();
        logic [31:0] data;
        logic [31:0] rdata;
        logic [31:0] r;
        logic [7:0]  off;
        hsize_t      size;
        hresp_t      first;
        hresp_t      last;
        int          waits;
        for (int w = 0; w < 64; w++) begin // Known contents first
            data = $urandom;
            off  = 8'(4 * w);
            do_transfer(0, RAM_BASE + {24'h0, off}, WORD, 1'b1, data, rdata, first, last, waits);
            check_okay("RAM fill write", last, waits);
            model_write(off, WORD, data);
        end
        for (int k = 0; k < 48; k++) begin
            r    = $urandom;
            data = $urandom;
            case (r[9:8])
                2'd0:    size = BYTE;
                2'd1:    size = HALF;
                default: size = WORD;
            endcase
            off    = r[7:0];
            off[0] = (size == BYTE) ? r[0] : 1'b0;  // Natural alignment
            off[1] = (size == WORD) ? 1'b0 : r[1];
            do_transfer(0, RAM_BASE + {24'h0, off}, size, 1'b1, data, rdata, first, last, waits);
            check_okay("RAM sized write", last, waits);
            model_write(off, size, data);
        end
        for (int w = 0; w < 64; w++) begin
            off = 8'(4 * w);
            do_transfer(0, RAM_BASE + {24'h0, off}, WORD, 1'b0, 32'h0, rdata, first, last, waits);
            check_okay("RAM read", last, waits);
            if (rdata !== model_word(off)) begin
                flag_mismatch($sformatf("RAM word at offset %h", off), rdata, model_word(off));
            end
        end
    endtask

    task automatic check_error_responses();
        logic [31:0] rdata;
        hresp_t      first;
        hresp_t      last;
        int          waits;
        do_transfer(0, 32'h4000_0000, WORD, 1'b0, 32'h0, rdata, first, last, waits);
        check_error("unmapped read", first, last, waits);
        do_transfer(0, ROM_BASE + 32'h10, WORD, 1'b1, ~rom_file[4], rdata, first, last, waits);
        check_error("ROM write", first, last, waits);
        do_transfer(0, ROM_BASE + 32'h10, WORD, 1'b0, 32'h0, rdata, first, last, waits);
        check_okay("ROM read after write", last, waits);
        if (rdata !== rom_file[4]) begin
            flag_mismatch("ROM word 4 after write", rdata, rom_file[4]);
        end
    endtask

    task automatic check_arbitration();
        logic [31:0] data;
        logic [31:0] rdata;
        hresp_t      first;
        hresp_t      last;
        int          waits;
        m1_busreq = 1'b1;                   // m0 still requesting
        @(negedge clk);
        if (m0_grant !== 1'b1 || m1_grant !== 1'b0) begin
            flag_mismatch("grants with both requesting", 32'({m1_grant, m0_grant}), 32'b01);
        end
        m0_busreq = 1'b0;
        @(negedge clk);                     // One idle edge later
        if (m1_grant !== 1'b1 || m0_grant !== 1'b0) begin
            flag_mismatch("grants after m0 release", 32'({m1_grant, m0_grant}), 32'b10);
        end
        wait_grant(1);
        data      = $urandom;
        m1_busreq = 1'b0;                   // Grant returns to m0 as m1's address phase ends
        m0_busreq = 1'b1;
        do_transfer(1, RAM_BASE + 32'h100, WORD, 1'b1, data, rdata, first, last, waits);
        check_okay("m1 RAM write", last, waits);
        if (m0_grant !== 1'b1 || m1_grant !== 1'b0) begin // m1 still owns the data phase
            flag_mismatch("grants in m1 data phase", 32'({m1_grant, m0_grant}), 32'b01);
        end
        wait_grant(0);
        do_transfer(0, RAM_BASE + 32'h100, WORD, 1'b0, 32'h0, rdata, first, last, waits);
        check_okay("m0 readback", last, waits);
        if (rdata !== data) begin
            flag_mismatch("m0 readback of m1 write", rdata, data);
        end
    endtask

    // Read address phase rides on the write data phase
    task automatic check_pipelining();
        logic [31:0] data;
        logic [31:0] rdata;
        hresp_t      first;
        hresp_t      last;
        int          waits;
        data = $urandom;
        do_transfer(0, RAM_BASE + 32'h200, WORD, 1'b1, data, rdata, first, last, waits);
        check_okay("pipelined write", last, waits);
        do_transfer(0, RAM_BASE + 32'h200, WORD, 1'b0, 32'h0, rdata, first, last, waits);
        check_okay("pipelined read", last, waits);
        if (rdata !== data) begin
            flag_mismatch("pipelined read data", rdata, data);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        rst          = 1'b1;
        m0_busreq    = 1'b0;
        m1_busreq    = 1'b0;
        m0_req       = '0;  // IDLE
        m1_req       = '0;
        value_errors = 0;
        timeouts     = 0;
        void'($urandom(32'h2606_f7bd));
        $readmemh("rom_init.hex", rom_file);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        m0_busreq = 1'b1;
        wait_grant(0);
        read_rom();
        exercise_ram_sizes();
        check_error_responses();
        check_arbitration();
        check_pipelining();
        $display("Error counts: %0d wrong values, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verif/tb_clock_gen.sv */
// Free-running testbench clock, starts low at time zero, PERIOD in ns
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0; // No rising edge at time zero
    end

    always #(PERIOD / 2) clk = ~clk; // Half period per toggle

endmodule

/* logic/ahb_sopc_top.sv */
// Bus fabric only: two external masters, ROM at 0x0000_0000 and RAM at 0x2000_0000, no wait states
`timescale 1ns/1ns

module ahb_sopc_top #(
    parameter int ROM_WORDS = 256,  // Power of two, fits the region
    parameter int RAM_WORDS = 1024
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             m0_busreq,
    input  logic             m1_busreq,
    input  ahb_pkg::ahb_req_t m0_req,
    input  ahb_pkg::ahb_req_t m1_req,
    output logic             m0_grant,
    output logic             m1_grant,
    output ahb_pkg::ahb_rsp_t m_rsp    // Shared by both masters
);
    import ahb_pkg::*;

    ahb_req_t s_req;   // Granted request to the slaves
    ahb_rsp_t rom_rsp;
    ahb_rsp_t ram_rsp;
    logic     rom_sel;
    logic     ram_sel;

    ////////////////////
    // Arbiter and decoder
    ////////////////////
    ahb_arbiter ahb_arbiter_inst (
        .clk       (clk),
        .rst       (rst),
        .m0_busreq (m0_busreq),
        .m1_busreq (m1_busreq),
        .m0_req    (m0_req),
        .m1_req    (m1_req),
        .hready    (m_rsp.hready),
        .m0_grant  (m0_grant),
        .m1_grant  (m1_grant),
        .s_req     (s_req)
    );

    ahb_decoder ahb_decoder_inst (
        .clk     (clk),
        .rst     (rst),
        .s_req   (s_req),
        .rom_rsp (rom_rsp),
        .ram_rsp (ram_rsp),
        .rom_sel (rom_sel),
        .ram_sel (ram_sel),
        .m_rsp   (m_rsp)
    );

    ////////////////////
    // Slaves
    ////////////////////
    ahb_mem_slave #(
        .WORDS    (ROM_WORDS),
        .WRITABLE (1'b0)       // Writes answered with ERROR
    ) rom_inst (
        .clk    (clk),
        .rst    (rst),
        .sel    (rom_sel),
        .s_req  (s_req),
        .hready (m_rsp.hready),
        .rsp    (rom_rsp)
    );

    ahb_mem_slave #(
        .WORDS    (RAM_WORDS),
        .WRITABLE (1'b1)
    ) ram_inst (
        .clk    (clk),
        .rst    (rst),
        .sel    (ram_sel),
        .s_req  (s_req),
        .hready (m_rsp.hready),
        .rsp    (ram_rsp)
    );

endmodule

/* logic/ahb_mem_slave.sv */
// Zero-wait word memory, WORDS must be a power of two >= 2; read-only copy loads rom_init.hex from the run dir
`timescale 1ns/1ns

module ahb_mem_slave #(
    parameter int WORDS    = 256,
    parameter bit WRITABLE = 1'b1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             sel,
    input  ahb_pkg::ahb_req_t s_req,
    input  logic             hready,  // Bus-wide ready, ends the address phase
    output ahb_pkg::ahb_rsp_t rsp
);
    import ahb_pkg::*;

    localparam int AW = $clog2(WORDS);

    logic [DATA_W-1:0] mem [WORDS];

    logic          accept;      // Address phase taken this edge
    logic          wr_err;      // Write to a read-only copy
    logic [AW+1:0] dp_addr_q;   // Byte address of data phase
    hsize_t        dp_size_q;
    logic          dp_write_q;
    logic          dp_valid_q;  // OKAY data phase pending
    logic          err_first_q; // ERROR, ready low
    logic          err_second_q;// ERROR, ready high
    logic [3:0]    lane_en;

    initial begin
        if (!WRITABLE) begin
            $readmemh("rom_init.hex", mem);
        end
    end

    assign accept = sel && hready &&
                    ((s_req.htrans == NONSEQ) || (s_req.htrans == SEQ));
    assign wr_err = s_req.hwrite && !WRITABLE;

    ////////////////////
    // Address phase
    ////////////////////

    // Payload captured without reset
    always_ff @(posedge clk) begin
        if (accept) begin
            dp_addr_q  <= s_req.haddr[AW+1:0];
            dp_size_q  <= s_req.hsize;
            dp_write_q <= s_req.hwrite;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dp_valid_q   <= 1'b0;
            err_first_q  <= 1'b0;
            err_second_q <= 1'b0;
        end else begin
            err_second_q <= err_first_q;
            if (hready) begin
                dp_valid_q  <= accept && !wr_err;
                err_first_q <= accept && wr_err;
            end else begin
                err_first_q <= 1'b0; // Only lasts one cycle
            end
        end
    end

    ////////////////////
    // Data phase
    ////////////////////

    // Byte lanes from size and low address bits
    always_comb begin
        case (dp_size_q)
            BYTE:    lane_en = 4'b0001 << dp_addr_q[1:0];
            HALF:    lane_en = dp_addr_q[1] ? 4'b1100 : 4'b0011;
            default: lane_en = 4'b1111;
        endcase
    end

    // Commit at the end of the data phase
    always_ff @(posedge clk) begin
        if (WRITABLE && dp_valid_q && dp_write_q && hready) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) begin
                    mem[dp_addr_q[AW+1:2]][8*b +: 8] <= s_req.hwdata[8*b +: 8];
                end
            end
        end
    end

    assign rsp.hrdata = mem[dp_addr_q[AW+1:2]]; // Async read, sees last commit
    assign rsp.hready = !err_first_q;
    assign rsp.hresp  = (err_first_q || err_second_q) ? ERROR : OKAY;

endmodule

/* logic/ahb_decoder.sv */
// Two mapped regions (ROM, RAM) on haddr[31:28], everything else hits the built-in two-cycle ERROR slave
`timescale 1ns/1ns

module ahb_decoder (
    input  logic             clk,
    input  logic             rst,
    input  ahb_pkg::ahb_req_t s_req,
    input  ahb_pkg::ahb_rsp_t rom_rsp,
    input  ahb_pkg::ahb_rsp_t ram_rsp,
    output logic             rom_sel,
    output logic             ram_sel,
    output ahb_pkg::ahb_rsp_t m_rsp
);
    import ahb_pkg::*;

    // Which slave answers the current data phase
    typedef enum logic [1:0] {
        DP_NONE,
        DP_ROM,
        DP_RAM,
        DP_DEF
    } dp_slave_t;

    // Default slave, ERR1 = ready low, ERR2 = ready high
    typedef enum logic [1:0] {
        DEF_IDLE,
        DEF_ERR1,
        DEF_ERR2
    } def_state_t;

    logic       active;   // NONSEQ or SEQ on the bus
    logic       rom_hit;
    logic       ram_hit;
    logic       def_sel;  // Active transfer, unmapped region
    dp_slave_t  dp_slave_q;
    def_state_t def_state_q;

    ////////////////////
    // Address decode
    ////////////////////
    assign active  = (s_req.htrans == NONSEQ) || (s_req.htrans == SEQ);
    assign rom_hit = s_req.haddr[ADDR_W-1:REGION_SHIFT] == ROM_BASE[ADDR_W-1:REGION_SHIFT];
    assign ram_hit = s_req.haddr[ADDR_W-1:REGION_SHIFT] == RAM_BASE[ADDR_W-1:REGION_SHIFT];

    assign rom_sel = active && rom_hit;
    assign ram_sel = active && ram_hit;
    assign def_sel = active && !rom_hit && !ram_hit;

    // Latch the selected slave when the address phase completes
    always_ff @(posedge clk) begin
        if (rst) begin
            dp_slave_q <= DP_NONE;
        end else if (m_rsp.hready) begin
            if (rom_sel) begin
                dp_slave_q <= DP_ROM;
            end else if (ram_sel) begin
                dp_slave_q <= DP_RAM;
            end else if (def_sel) begin
                dp_slave_q <= DP_DEF;
            end else begin
                dp_slave_q <= DP_NONE; // Idle cycle, no data phase
            end
        end
    end

    ////////////////////
    // Default slave
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            def_state_q <= DEF_IDLE;
        end else if (m_rsp.hready) begin
            def_state_q <= def_sel ? DEF_ERR1 : DEF_IDLE; // Back-to-back errors allowed
        end else if (def_state_q == DEF_ERR1) begin
            def_state_q <= DEF_ERR2;
        end
    end

    ////////////////////
    // Response mux
    ////////////////////
    always_comb begin
        m_rsp.hrdata = '0;
        m_rsp.hready = 1'b1;
        m_rsp.hresp  = OKAY;
        case (dp_slave_q)
            DP_ROM: m_rsp = rom_rsp;
            DP_RAM: m_rsp = ram_rsp;
            DP_DEF: begin
                m_rsp.hready = (def_state_q != DEF_ERR1); // Low only in first error cycle
                m_rsp.hresp  = ERROR;
            end
            default: ; // No data phase, idle OKAY
        endcase
    end

endmodule

/* logic/ahb_arbiter.sv */
// Two-master fixed priority (m0 wins), grant parks on m0 after reset and moves only when hready is high
`timescale 1ns/1ns

module ahb_arbiter (
    input  logic             clk,
    input  logic             rst,
    input  logic             m0_busreq,
    input  logic             m1_busreq,
    input  ahb_pkg::ahb_req_t m0_req,
    input  ahb_pkg::ahb_req_t m1_req,
    input  logic             hready,     // Bus-wide ready from the response mux
    output logic             m0_grant,
    output logic             m1_grant,
    output ahb_pkg::ahb_req_t s_req
);
    import ahb_pkg::*;

    logic [1:0] grant_q;    // One-hot, bit 0 = m0
    logic       dp_owner_q; // Master owning the data phase, 1 = m1

    ////////////////////
    // Grant register
    ////////////////////

    // Priority pick evaluated on every ready edge
    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= 2'b01; // Park on m0
        end else if (hready) begin
            if (m0_busreq) begin
                grant_q <= 2'b01;
            end else if (m1_busreq) begin
                grant_q <= 2'b10;
            end
            // No request, keep present owner
        end
    end

    assign m0_grant = grant_q[0];
    assign m1_grant = grant_q[1];

    ////////////////////
    // Data-phase owner
    ////////////////////

    // The address-phase owner moves into the data phase at a ready edge
    always_ff @(posedge clk) begin
        if (rst) begin
            dp_owner_q <= 1'b0;
        end else if (hready) begin
            dp_owner_q <= grant_q[1];
        end
    end

    ////////////////////
    // Request mux
    ////////////////////

    // Address/control from the granted master,
    // write data from whoever owns the data phase (grant may have moved on)
    always_comb begin
        if (grant_q[1]) begin
            s_req = m1_req;
        end else begin
            s_req = m0_req;
        end
        if (dp_owner_q) begin
            s_req.hwdata = m1_req.hwdata;
        end else begin
            s_req.hwdata = m0_req.hwdata;
        end
    end

endmodule

/* logic/ahb_pkg.sv */
// AHB-lite subset shared types: single 32-bit bus, no bursts/lock/prot/split, 4-bit region decode
package ahb_pkg;

    ////////////////////
    // Bus widths
    ////////////////////
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // HTRANS encoding, only NONSEQ and SEQ start a transfer
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // HSIZE, nothing wider than the data bus
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    // HRESP without RETRY/SPLIT
    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_t;

    ////////////////////
    // Bus bundles
    ////////////////////
    typedef struct packed {
        logic [ADDR_W-1:0] haddr;  // Address phase
        htrans_t           htrans;
        hsize_t            hsize;
        logic              hwrite;
        logic [DATA_W-1:0] hwdata; // Data phase, one cycle later
    } ahb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] hrdata;
        logic              hready;
        hresp_t            hresp;
    } ahb_rsp_t;

    ////////////////////
    // Memory map
    ////////////////////
    localparam logic [ADDR_W-1:0] ROM_BASE = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] RAM_BASE = 32'h2000_0000;
    localparam int REGION_SHIFT = 28; // haddr[31:28] picks the region

endpackage
